//--- verilog.f
+incdir+dv
verilog/ppu_pkg.sv
verilog/window_detector.sv
verilog/window_masker.sv
verilog/layer_priority.sv
verilog/palette_ram.sv
verilog/palette_fetch.sv
verilog/pixel_compositor.sv
dv/pixel_compositor_tb.sv

//--- Makefile
# Verilator flow for the pixel compositor
VERILATOR ?= verilator
TOP       ?= pixel_compositor_tb
RTL_TOP   ?= pixel_compositor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) dv/compositor_model.svh
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/compositor_model.svh
`ifndef COMPOSITOR_MODEL_SVH
`define COMPOSITOR_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the compositing rules

function automatic logic covers(input logic [7:0] pos, input logic [15:0] bound);
    return (pos >= bound[15:8]) && (pos < bound[7:0]);   // Start in, end out
endfunction

// Returns {effects, layer enables} for one candidate cycle
function automatic logic [5:0] model_group(input display_regs_t r, input logic [7:0] c,
                                           input logic [7:0] l, input layer_entry_t obj);
    logic in0;
    logic in1;
    logic in_obj;
    in0    = r.ctrl.win0_en && covers(c, r.win0_h) && covers(l, r.win0_v);
    in1    = r.ctrl.win1_en && covers(c, r.win1_h) && covers(l, r.win1_v);
    in_obj = r.ctrl.objwin_en && obj.valid && obj.mode == 2'd2;
    if (!(r.ctrl.win0_en || r.ctrl.win1_en || r.ctrl.objwin_en))
        return 6'b11_1111;
    if (in0)
        return r.win_in.win0;
    if (in1)
        return r.win_in.win1;
    if (in_obj)
        return r.win_out.objwin;
    return r.win_out.outside;
endfunction

function automatic logic model_visible(input layer_entry_t e, input logic [4:0] layers);
    if (!e.valid || e.mode == 2'd2)
        return 1'b0;
    return layers[e.layer];
endfunction

// True when a sits in front of b
function automatic logic in_front(input layer_entry_t a, input layer_entry_t b);
    if (a.prio != b.prio)
        return a.prio < b.prio;
    if (a.layer == 3'd4 && b.layer != 3'd4)
        return 1'b1;
    if (b.layer == 3'd4)
        return 1'b0;
    return a.layer < b.layer;
endfunction

function automatic color_t lookup(input logic [31:0] pal [256], input layer_entry_t e);
    logic [8:0]  addr;
    logic [31:0] word;
    addr = {e.layer == 3'd4, e.index};
    word = pal[addr[8:1]];
    return addr[0] ? word[30:16] : word[14:0];
endfunction

function automatic pixel_result_t model_pixel(input display_regs_t r, input logic [7:0] c,
                                              input logic [7:0] l, input candidate_t cands [4],
                                              input int n, input logic [31:0] pal [256]);
    layer_entry_t  front;
    layer_entry_t  second;
    layer_entry_t  slot [2];
    logic [5:0]    grp;
    pixel_result_t res;
    front  = '{valid: 1'b1, layer: 3'd5, prio: 2'd3, index: 8'd0, mode: 2'd0};
    second = front;
    grp    = '0;
    for (int i = 0; i < n; i++) begin
        grp     = model_group(r, c, l, cands[i].obj);
        slot[0] = cands[i].bg;
        slot[1] = cands[i].obj;
        for (int k = 0; k < 2; k++) begin
            if (model_visible(slot[k], grp[4:0])) begin
                if (in_front(slot[k], front)) begin
                    second = front;
                    front  = slot[k];
                end else if (in_front(slot[k], second)) begin
                    second = slot[k];
                end
            end
        end
    end
    res.color0  = lookup(pal, front);
    res.color1  = lookup(pal, second);
    res.layer0  = front.layer;
    res.layer1  = second.layer;
    res.effects = grp[5];   // From the last cycle
    return res;
endfunction

`endif

//--- dv/pixel_compositor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor_tb;
    import ppu_pkg::*;

    `include "compositor_model.svh"

    typedef struct {
        string         name;
        logic [7:0]    col;
        logic [7:0]    line;
        display_regs_t regs;
        candidate_t    cands [4];
        int            n;
    } pixel_case_t;

    logic           clk;
    logic           reset;
    logic           cand_valid;
    logic           pixel_start;
    logic           pixel_end;
    candidate_t     cand;
    logic     [7:0] col;
    logic     [7:0] line;
    display_regs_t  regs;
    logic           pal_wr;
    pal_word_addr_t pal_wr_addr;
    logic    [31:0] pal_wr_data;
    logic           pix_valid;
    pixel_result_t  pix;

    logic    [31:0] pal_copy [256];
    pixel_case_t    cases [$];
    pixel_result_t  exp_q [$];
    int             due_q [$];
    string          name_q [$];
    int             cycle;
    int             limit;
    int             errors;
    int             checks;

    pixel_compositor i_dut (
        .clk         (clk),
        .reset       (reset),
        .cand_valid  (cand_valid),
        .pixel_start (pixel_start),
        .pixel_end   (pixel_end),
        .cand        (cand),
        .col         (col),
        .line        (line),
        .regs        (regs),
        .pal_wr      (pal_wr),
        .pal_wr_addr (pal_wr_addr),
        .pal_wr_data (pal_wr_data),
        .pix_valid   (pix_valid),
        .pix         (pix)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry builders
    function automatic layer_entry_t bg(input int id, input int p, input int idx);
        return '{valid: 1'b1, layer: 3'(id), prio: 2'(p), index: 8'(idx), mode: 2'd0};
    endfunction

    function automatic layer_entry_t spr(input int p, input int idx, input int md);
        return '{valid: 1'b1, layer: 3'd4, prio: 2'(p), index: 8'(idx), mode: 2'(md)};
    endfunction

    function automatic candidate_t pair(input layer_entry_t b, input layer_entry_t o);
        return '{bg: b, obj: o};
    endfunction

    task automatic add_case(input string name, input int c, input int l,
                            input display_regs_t r, input int n, input candidate_t c0,
                            input candidate_t c1, input candidate_t c2, input candidate_t c3);
        pixel_case_t pc;
        pc.name     = name;
        pc.col      = 8'(c);
        pc.line     = 8'(l);
        pc.regs     = r;
        pc.n        = n;
        pc.cands[0] = c0;
        pc.cands[1] = c1;
        pc.cands[2] = c2;
        pc.cands[3] = c3;
        cases.push_back(pc);
    endtask

    task automatic build_table();
        display_regs_t off;
        display_regs_t w;
        display_regs_t w01;
        display_regs_t wobj;
        candidate_t    nil;
        candidate_t    win_c0;
        candidate_t    win_c1;
        nil = '0;
        off = '0;
        w   = '0;
        w.ctrl.win0_en     = 1'b1;
        w.win0_h           = {8'd10, 8'd20};
        w.win0_v           = {8'd5, 8'd15};
        w.win1_h           = {8'd15, 8'd30};
        w.win1_v           = {8'd0, 8'd40};
        w.win_in.win0      = {1'b1, 5'b00001};
        w.win_in.win1      = {1'b0, 5'b00110};
        w.win_out.outside  = {1'b0, 5'b10101};
        w.win_out.objwin   = {1'b1, 5'b00110};
        w01                = w;
        w01.ctrl.win1_en   = 1'b1;
        wobj               = w;
        wobj.ctrl          = 3'b100;   // Sprite window only
        win_c0 = pair(bg(0, 1, 8), spr(0, 8'h21, 0));
        win_c1 = pair(bg(1, 2, 9), '0);

        // Priority order with windows off
        add_case("prio_lower", 3, 3, off, 3, pair(bg(0, 2, 10), spr(1, 20, 0)),
                 pair(bg(1, 3, 5), '0), pair(bg(2, 0, 7), '0), nil);
        add_case("obj_tie", 4, 3, off, 3, pair(bg(1, 1, 3), spr(1, 4, 0)),
                 pair(bg(0, 2, 6), '0), nil, nil);
        add_case("bg_id_tie", 5, 3, off, 3, pair(bg(2, 1, 9), '0),
                 pair(bg(1, 1, 11), '0), pair(bg(3, 1, 12), '0), nil);
        add_case("four_cycles", 6, 3, off, 4, pair(bg(3, 3, 1), spr(3, 2, 0)),
                 pair(bg(2, 2, 13), '0), pair('0, spr(2, 14, 0)), pair(bg(0, 3, 15), '0));
        // Missing layers fall back to backdrop
        add_case("one_visible", 7, 3, off, 3, pair(bg(3, 2, 40), '0), nil, nil, nil);
        add_case("none_visible", 8, 3, off, 3, nil, nil, nil, nil);
        // Window bounds and precedence
        add_case("win0_start", 10, 5, w, 3, win_c0, win_c1, nil, nil);
        add_case("win0_end_col", 20, 5, w, 3, win_c0, win_c1, nil, nil);
        add_case("win0_end_line", 12, 15, w, 3, win_c0, win_c1, nil, nil);
        add_case("win_overlap", 16, 6, w01, 3, win_c0, win_c1, nil, nil);
        add_case("win1_only", 25, 6, w01, 3, win_c0, win_c1, pair(bg(2, 3, 17), '0), nil);
        add_case("win1_outside", 25, 40, w01, 3, win_c0, win_c1, nil, nil);
        // Sprite window switches the group, never drawn
        add_case("obj_window", 50, 50, wobj, 3, pair(bg(0, 1, 4), '0),
                 pair(bg(2, 0, 5), '0), pair(bg(1, 0, 6), spr(0, 7, 2)), nil);
        // Shared and separate palette words
        add_case("same_word_bg", 9, 9, off, 3, pair(bg(0, 0, 2), '0),
                 pair(bg(1, 1, 3), '0), nil, nil);
        add_case("same_word_obj", 9, 9, off, 3, pair('0, spr(0, 8'h80, 0)),
                 pair('0, spr(1, 8'h81, 0)), nil, nil);
        add_case("diff_word", 9, 9, off, 3, pair(bg(2, 1, 8'h90), spr(0, 8'h33, 0)),
                 nil, nil, nil);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result monitor and watchdog
    always @(negedge clk) begin
        if (!reset && cycle > limit) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycle, exp_q.size());
            $display("TESTS FAILED");
            $finish;
        end else if (!reset && pix_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Result strobe at cycle %0d with no pixel pending", cycle);
            end
            if (exp_q.size() > 0) begin
                assert (cycle == due_q[0]) else begin
                    errors++;
                    $display("Error %s: expected cycle %0d, actual cycle %0d",
                             name_q[0], due_q[0], cycle);
                end
                assert (pix == exp_q[0]) else begin
                    errors++;
                    $display("Error %s: expected %h, actual %h", name_q[0], exp_q[0], pix);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    initial begin
        reset       = 1'b1;
        cand_valid  = 1'b0;
        pixel_start = 1'b0;
        pixel_end   = 1'b0;
        cand        = '0;
        col         = '0;
        line        = '0;
        regs        = '0;
        pal_wr      = 1'b0;
        pal_wr_addr = '0;
        pal_wr_data = '0;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        void'($urandom(32'ha9ad));
        build_table();
        limit = cases.size() * 4 + 256 + 40;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Palette load
        for (int a = 0; a < 256; a++) begin
            pal_copy[a] = $urandom;
            @(posedge clk);
            pal_wr      <= 1'b1;
            pal_wr_addr <= 8'(a);
            pal_wr_data <= pal_copy[a];
        end
        @(posedge clk);
        pal_wr <= 1'b0;

        // Pixels back to back
        foreach (cases[p]) begin
            for (int c = 0; c < cases[p].n; c++) begin
                @(posedge clk);
                cand_valid  <= 1'b1;
                pixel_start <= (c == 0);
                pixel_end   <= (c == cases[p].n - 1);
                cand        <= cases[p].cands[c];
                col         <= cases[p].col;
                line        <= cases[p].line;
                regs        <= cases[p].regs;
                if (c == cases[p].n - 1) begin
                    exp_q.push_back(model_pixel(cases[p].regs, cases[p].col, cases[p].line,
                                                cases[p].cands, cases[p].n, pal_copy));
                    due_q.push_back(cycle + 4);   // Pixel_end cycle plus three
                    name_q.push_back(cases[p].name);
                end
            end
        end
        @(posedge clk);
        cand_valid  <= 1'b0;
        pixel_start <= 1'b0;
        pixel_end   <= 1'b0;

        while (exp_q.size() > 0) @(posedge clk);
        repeat (4) @(posedge clk);

        assert (checks == cases.size()) else begin
            errors++;
            $display("Got %0d results for %0d pixels", checks, cases.size());
        end
        $display("Results checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pixel_compositor.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cand_valid,
    input  logic                    pixel_start,
    input  logic                    pixel_end,
    input  ppu_pkg::candidate_t     cand,
    input  logic              [7:0] col,
    input  logic              [7:0] line,
    input  ppu_pkg::display_regs_t  regs,
    input  logic                    pal_wr,
    input  ppu_pkg::pal_word_addr_t pal_wr_addr,
    input  logic             [31:0] pal_wr_data,
    output logic                    pix_valid,
    output ppu_pkg::pixel_result_t  pix
);
    import ppu_pkg::*;

    logic           win0;
    logic           win1;
    logic           obj_win;
    layer_mask_t    mask;
    logic           effects;
    layer_entry_t   top;
    layer_entry_t   bottom;
    logic           effects_hold;
    pal_word_addr_t rd_addr;
    logic    [31:0] rd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    window_detector i_window_detector (
        .col     (col),
        .line    (line),
        .regs    (regs),
        .obj     (cand.obj),
        .win0    (win0),
        .win1    (win1),
        .obj_win (obj_win)
    );

    window_masker i_window_masker (
        .win0    (win0),
        .win1    (win1),
        .obj_win (obj_win),
        .regs    (regs),
        .mask    (mask),
        .effects (effects)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute
    layer_priority i_layer_priority (
        .clk          (clk),
        .reset        (reset),
        .cand_valid   (cand_valid),
        .pixel_start  (pixel_start),
        .pixel_end    (pixel_end),
        .cand         (cand),
        .mask         (mask),
        .effects      (effects),
        .top          (top),
        .bottom       (bottom),
        .effects_hold (effects_hold)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    palette_ram i_palette_ram (
        .clk     (clk),
        .wr      (pal_wr),
        .wr_addr (pal_wr_addr),
        .wr_data (pal_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    palette_fetch i_palette_fetch (
        .clk       (clk),
        .reset     (reset),
        .pixel_end (pixel_end),
        .top       (top),
        .bottom    (bottom),
        .effects   (effects_hold),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .pix_valid (pix_valid),
        .pix       (pix)
    );

endmodule

`default_nettype wire

//--- verilog/palette_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module palette_fetch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pixel_end,
    input  ppu_pkg::layer_entry_t   top,
    input  ppu_pkg::layer_entry_t   bottom,
    input  logic                    effects,
    output ppu_pkg::pal_word_addr_t rd_addr,
    input  logic             [31:0] rd_data,
    output logic                    pix_valid,
    output ppu_pkg::pixel_result_t  pix
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ_TOP,
        READ_BOT
    } fetch_state_t;

    fetch_state_t state;
    layer_entry_t top_q;
    layer_entry_t bot_q;
    logic         effects_q;
    logic  [31:0] top_word_q;
    logic  [31:0] bot_word;
    pal_addr_t    top_addr;
    pal_addr_t    bot_addr;
    logic         same_word;

    // OBJ colors live in the upper half of the palette
    function automatic pal_addr_t color_addr(input layer_entry_t e);
        return {e.layer == LAYER_OBJ, e.index};
    endfunction

    function automatic color_t pick_half(input logic [31:0] word, input logic upper);
        return upper ? word[30:16] : word[14:0];
    endfunction

    assign top_addr  = color_addr(top_q);
    assign bot_addr  = color_addr(bot_q);
    assign same_word = (top_addr[8:1] == bot_addr[8:1]);
    assign rd_addr   = (state == READ_BOT) ? bot_addr[8:1] : top_addr[8:1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch sequence, result lands one cycle after READ_BOT
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= (state == READ_BOT);
            case (state)
                IDLE:     if (pixel_end) state <= READ_TOP;
                READ_TOP: state <= READ_BOT;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && pixel_end) begin
            top_q     <= top;   // Snapshot the sorted pair
            bot_q     <= bottom;
            effects_q <= effects;
        end
        if (state == READ_BOT) begin
            top_word_q <= rd_data;
        end
    end

    // Shared word needs no second read
    assign bot_word = same_word ? top_word_q : rd_data;

    always_comb begin
        pix.color0  = pick_half(top_word_q, top_addr[0]);
        pix.color1  = pick_half(bot_word, bot_addr[0]);
        pix.layer0  = top_q.layer;
        pix.layer1  = bot_q.layer;
        pix.effects = effects_q;
    end

endmodule

`default_nettype wire

//--- verilog/palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module palette_ram (
    input  logic                    clk,
    input  logic                    wr,
    input  ppu_pkg::pal_word_addr_t wr_addr,
    input  logic             [31:0] wr_data,
    input  ppu_pkg::pal_word_addr_t rd_addr,
    output logic             [31:0] rd_data
);

    // Lower color address sits in bits 15:0
    logic [31:0] mem [256];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // One cycle read
    end

endmodule

`default_nettype wire

//--- verilog/layer_priority.sv
`timescale 1ns/1ps
`default_nettype none

module layer_priority (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cand_valid,
    input  logic                  pixel_start,
    input  logic                  pixel_end,
    input  ppu_pkg::candidate_t   cand,
    input  ppu_pkg::layer_mask_t  mask,
    input  logic                  effects,
    output ppu_pkg::layer_entry_t top,
    output ppu_pkg::layer_entry_t bottom,
    output logic                  effects_hold
);
    import ppu_pkg::*;

    layer_entry_t top_q;
    layer_entry_t bot_q;
    layer_entry_t base_top;
    layer_entry_t base_bot;
    logic         restart;
    logic         bg_vis;
    logic         obj_vis;
    logic         bg_over_obj;
    logic         bg_top;
    logic         obj_top;
    logic         bg_bot;
    logic         obj_bot;
    logic         effects_q;

    // Lower key is further front, OBJ wins a priority tie
    function automatic logic [4:0] sort_key(input layer_entry_t e);
        logic [2:0] rank;
        rank = (e.layer == LAYER_OBJ) ? 3'd0 : e.layer + 3'd1;
        return {e.prio, rank};
    endfunction

    function automatic logic visible(input layer_entry_t e, input layer_mask_t m);
        logic enabled;
        enabled = (e.layer == LAYER_OBJ) ? m[LAYER_OBJ] : m[e.layer[1:0]];
        return e.valid && (e.mode != OBJ_MODE_WINDOW) && enabled;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare stage
    assign restart  = cand_valid && pixel_start;
    assign base_top = restart ? BACKDROP_ENTRY : top_q;   // New pixel starts on backdrop
    assign base_bot = restart ? BACKDROP_ENTRY : bot_q;

    assign bg_vis      = cand_valid && visible(cand.bg, mask);
    assign obj_vis     = cand_valid && visible(cand.obj, mask);
    assign bg_over_obj = sort_key(cand.bg) < sort_key(cand.obj);

    assign bg_top  = bg_vis  && (sort_key(cand.bg)  < sort_key(base_top));
    assign obj_top = obj_vis && (sort_key(cand.obj) < sort_key(base_top));
    assign bg_bot  = bg_vis  && (sort_key(cand.bg)  < sort_key(base_bot));
    assign obj_bot = obj_vis && (sort_key(cand.obj) < sort_key(base_bot));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Merge into the held pair, outputs bypass the register
    always_comb begin
        if (bg_top && obj_top) begin
            top    = bg_over_obj ? cand.bg  : cand.obj;
            bottom = bg_over_obj ? cand.obj : cand.bg;
        end else if (bg_top) begin
            top    = cand.bg;
            bottom = base_top;   // Old top pushed down
        end else if (obj_top) begin
            top    = cand.obj;
            bottom = base_top;
        end else begin
            top = base_top;
            if (bg_bot && obj_bot) begin
                bottom = bg_over_obj ? cand.bg : cand.obj;
            end else if (bg_bot) begin
                bottom = cand.bg;
            end else if (obj_bot) begin
                bottom = cand.obj;
            end else begin
                bottom = base_bot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            top_q     <= BACKDROP_ENTRY;
            bot_q     <= BACKDROP_ENTRY;
            effects_q <= 1'b0;
        end else if (cand_valid) begin
            top_q <= top;
            bot_q <= bottom;
            if (pixel_end) begin
                effects_q <= effects;
            end
        end
    end

    assign effects_hold = (cand_valid && pixel_end) ? effects : effects_q;

endmodule

`default_nettype wire

//--- verilog/window_masker.sv
`timescale 1ns/1ps
`default_nettype none

module window_masker (
    input  logic                   win0,
    input  logic                   win1,
    input  logic                   obj_win,
    input  ppu_pkg::display_regs_t regs,
    output ppu_pkg::layer_mask_t   mask,
    output logic                   effects
);
    import ppu_pkg::*;

    logic       any_window;
    win_group_t group;

    assign any_window = regs.ctrl.win0_en || regs.ctrl.win1_en || regs.ctrl.objwin_en;

    // Window 0 beats window 1 beats sprite window beats outside
    always_comb begin
        if (!any_window) begin
            group.layers  = '1;   // Windowing off
            group.effects = 1'b1;
        end else if (win0) begin
            group = regs.win_in.win0;
        end else if (win1) begin
            group = regs.win_in.win1;
        end else if (obj_win) begin
            group = regs.win_out.objwin;
        end else begin
            group = regs.win_out.outside;
        end
    end

    assign mask    = group.layers;
    assign effects = group.effects;

endmodule

`default_nettype wire

//--- verilog/window_detector.sv
`timescale 1ns/1ps
`default_nettype none

module window_detector (
    input  logic                   [7:0] col,
    input  logic                   [7:0] line,
    input  ppu_pkg::display_regs_t       regs,
    input  ppu_pkg::layer_entry_t        obj,
    output logic                         win0,
    output logic                         win1,
    output logic                         obj_win
);
    import ppu_pkg::*;

    logic win0_h_hit;
    logic win0_v_hit;
    logic win1_h_hit;
    logic win1_v_hit;

    // Start inclusive, stop exclusive
    function automatic logic in_span(input logic [7:0] pos, input win_bound_t bound);
        return (pos >= bound.start) && (pos < bound.stop);
    endfunction

    assign win0_h_hit = in_span(col, regs.win0_h);
    assign win0_v_hit = in_span(line, regs.win0_v);
    assign win1_h_hit = in_span(col, regs.win1_h);
    assign win1_v_hit = in_span(line, regs.win1_v);

    assign win0 = regs.ctrl.win0_en && win0_h_hit && win0_v_hit;
    assign win1 = regs.ctrl.win1_en && win1_h_hit && win1_v_hit;

    // Sprite window pixels come in on the OBJ slot
    assign obj_win = regs.ctrl.objwin_en && obj.valid && (obj.mode == OBJ_MODE_WINDOW);

endmodule

`default_nettype wire

//--- verilog/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths fixed by the display format
    typedef logic [14:0] color_t;
    typedef logic [7:0]  pal_index_t;
    typedef logic [8:0]  pal_addr_t;       // {sprite flag, index}
    typedef logic [7:0]  pal_word_addr_t;  // Color address without bit 0
    typedef logic [1:0]  prio_t;           // Lower is in front
    typedef logic [2:0]  layer_id_t;
    typedef logic [4:0]  layer_mask_t;     // BG0..BG3 in 3:0, OBJ in 4

    localparam layer_id_t LAYER_BG0      = 3'd0;
    localparam layer_id_t LAYER_BG1      = 3'd1;
    localparam layer_id_t LAYER_BG2      = 3'd2;
    localparam layer_id_t LAYER_BG3      = 3'd3;
    localparam layer_id_t LAYER_OBJ      = 3'd4;
    localparam layer_id_t LAYER_BACKDROP = 3'd5;

    localparam logic [1:0] OBJ_MODE_WINDOW = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Candidate entries
    typedef struct packed {
        logic       valid;
        layer_id_t  layer;
        prio_t      prio;
        pal_index_t index;
        logic [1:0] mode;   // Sprite mode, 2 is window only
    } layer_entry_t;

    typedef struct packed {
        layer_entry_t bg;
        layer_entry_t obj;
    } candidate_t;

    localparam layer_entry_t BACKDROP_ENTRY = '{
        valid: 1'b1,
        layer: LAYER_BACKDROP,
        prio:  2'd3,
        index: 8'd0,
        mode:  2'd0
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window and display control registers
    typedef struct packed {
        logic [7:0] start;
        logic [7:0] stop;   // Exclusive
    } win_bound_t;

    typedef struct packed {
        logic        effects;
        layer_mask_t layers;
    } win_group_t;

    typedef struct packed {
        logic objwin_en;
        logic win1_en;
        logic win0_en;
    } disp_ctrl_t;

    typedef struct packed {
        win_group_t win1;
        win_group_t win0;
    } win_in_t;

    typedef struct packed {
        win_group_t objwin;
        win_group_t outside;
    } win_out_t;

    typedef struct packed {
        disp_ctrl_t ctrl;
        win_bound_t win0_h;
        win_bound_t win0_v;
        win_bound_t win1_h;
        win_bound_t win1_v;
        win_in_t    win_in;
        win_out_t   win_out;
    } display_regs_t;

    typedef struct packed {
        color_t    color0;
        color_t    color1;
        layer_id_t layer0;
        layer_id_t layer1;
        logic      effects;
    } pixel_result_t;

endpackage

`default_nettype wire
